// ==== logic/l3_cfg.svh ====
`ifndef L3_CFG_SVH
`define L3_CFG_SVH

// Byte address width
`define L3_ADDR_W 16

// Cache geometry
`define L3_SETS 16
`define L3_WAYS 4

// Backing memory access latency in cycles
`define L3_MEM_LAT 4

`endif

// ==== logic/l3_pkg.sv ====
`include "l3_cfg.svh"

package l3_pkg;

    typedef logic [31:0] word_t;

    typedef logic [$clog2(`L3_SETS)-1:0] set_idx_t;

    typedef logic [$clog2(`L3_WAYS)-1:0] way_idx_t;

    // Address bits above set index and byte offset
    typedef logic [`L3_ADDR_W-$clog2(`L3_SETS)-3:0] tag_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } tag_entry_t;

    typedef logic [$clog2(`L3_WAYS)-1:0] age_t;

endpackage

// ==== logic/l3_set_ram.sv ====
`include "l3_cfg.svh"

module l3_set_ram import l3_pkg::*; #(
    parameter type entry_t = logic,
    parameter int  DEPTH   = `L3_SETS,
    parameter int  WAYS    = `L3_WAYS
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     we_i,
    input  set_idx_t wset_i,
    input  way_idx_t wway_i,
    input  entry_t   wdata_i,
    input  set_idx_t rset_i,
    output entry_t   rdata_o [WAYS]
);

    entry_t mem_q [DEPTH][WAYS];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int s = 0; s < DEPTH; s++) begin
                for (int w = 0; w < WAYS; w++) begin
                    mem_q[s][w] <= '0;
                end
            end
        end else if (we_i) begin
            mem_q[wset_i][wway_i] <= wdata_i;
        end
    end

    // Whole set visible at once for the tag compare
    assign rdata_o = mem_q[rset_i];

endmodule

// ==== logic/l3_lookup.sv ====
`include "l3_cfg.svh"

module l3_lookup import l3_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`L3_ADDR_W-1:0] addr_i,
    input  logic                  touch_i,
    input  logic                  wr_en_i,
    input  logic                  refill_i,
    input  word_t                 wdata_i,
    input  logic [3:0]            be_i,
    input  word_t                 fill_data_i,
    output logic                  hit_o,
    output word_t                 rd_data_o
);

    set_idx_t   set_idx;
    tag_t       addr_tag;

    tag_entry_t tag_rd [`L3_WAYS];
    word_t      data_rd [`L3_WAYS];
    age_t       age_q [`L3_SETS][`L3_WAYS];

    way_idx_t   hit_way;
    way_idx_t   victim_way;
    way_idx_t   used_way;
    logic       found_inv;
    logic       age_upd;
    word_t      merged;

    logic       data_we;
    way_idx_t   data_way;
    word_t      data_wr;
    tag_entry_t tag_wr;

    // Byte offset occupies the two low bits
    assign set_idx  = addr_i[$clog2(`L3_SETS)+1:2];
    assign addr_tag = addr_i[`L3_ADDR_W-1:$clog2(`L3_SETS)+2];

    always_comb begin
        hit_o   = 1'b0;
        hit_way = '0;
        for (int w = 0; w < `L3_WAYS; w++) begin
            if (tag_rd[w].valid && tag_rd[w].tag == addr_tag) begin
                hit_o   = 1'b1;
                hit_way = way_idx_t'(w);
            end
        end
    end

    assign rd_data_o = data_rd[hit_way];

    // Victim is the first free way, else the least recent one
    always_comb begin
        victim_way = '0;
        found_inv  = 1'b0;
        for (int w = 0; w < `L3_WAYS; w++) begin
            if (!tag_rd[w].valid && !found_inv) begin
                victim_way = way_idx_t'(w);
                found_inv  = 1'b1;
            end
        end
        if (!found_inv) begin
            for (int w = 1; w < `L3_WAYS; w++) begin
                if (age_q[set_idx][w] < age_q[set_idx][victim_way]) begin
                    victim_way = way_idx_t'(w);
                end
            end
        end
    end

    assign age_upd  = touch_i | wr_en_i | refill_i;
    assign used_way = refill_i ? victim_way : hit_way;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int s = 0; s < `L3_SETS; s++) begin
                for (int w = 0; w < `L3_WAYS; w++) begin
                    age_q[s][w] <= '0;
                end
            end
        end else if (age_upd) begin
            for (int w = 0; w < `L3_WAYS; w++) begin
                if (way_idx_t'(w) == used_way) begin
                    age_q[set_idx][w] <= age_t'(`L3_WAYS - 1);
                end else if (age_q[set_idx][w] > age_q[set_idx][used_way]) begin
                    age_q[set_idx][w] <= age_q[set_idx][w] - 1'b1;
                end
            end
        end
    end

    always_comb begin
        merged = data_rd[hit_way];
        for (int b = 0; b < 4; b++) begin
            if (be_i[b]) begin
                merged[8*b +: 8] = wdata_i[8*b +: 8];
            end
        end
    end

    assign data_we  = wr_en_i | refill_i;
    assign data_way = refill_i ? victim_way : hit_way;
    assign data_wr  = refill_i ? fill_data_i : merged;
    assign tag_wr   = tag_entry_t'{valid: 1'b1, tag: addr_tag};

    l3_set_ram #(
        .entry_t (tag_entry_t)
    ) tag_ram_i (
        .clk     (clk),
        .rst     (rst),
        .we_i    (refill_i),
        .wset_i  (set_idx),
        .wway_i  (victim_way),
        .wdata_i (tag_wr),
        .rset_i  (set_idx),
        .rdata_o (tag_rd)
    );

    l3_set_ram #(
        .entry_t (word_t)
    ) data_ram_i (
        .clk     (clk),
        .rst     (rst),
        .we_i    (data_we),
        .wset_i  (set_idx),
        .wway_i  (data_way),
        .wdata_i (data_wr),
        .rset_i  (set_idx),
        .rdata_o (data_rd)
    );

endmodule

// ==== logic/l3_miss_fsm.sv ====
`include "l3_cfg.svh"

module l3_miss_fsm import l3_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_i,
    input  logic                  wr_i,
    input  logic [`L3_ADDR_W-1:0] addr_i,
    input  logic                  hit_i,
    input  word_t                 rd_data_i,
    input  word_t                 mem_data_i,
    input  logic                  done_i,
    output logic [`L3_ADDR_W-1:0] lk_addr_o,
    output logic                  touch_o,
    output logic                  wr_en_o,
    output logic                  refill_o,
    output logic                  mem_we_o,
    output logic                  start_o,
    output logic                  busy_o,
    output logic                  rsp_valid_o,
    output logic                  rsp_hit_o,
    output word_t                 rsp_data_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT,
        ST_REFILL
    } state_t;

    state_t                state_q;
    logic [`L3_ADDR_W-1:0] miss_addr_q;
    logic                  idle_req;

    assign idle_req = (state_q == ST_IDLE) && req_i;

    assign lk_addr_o = (state_q == ST_IDLE) ? addr_i : miss_addr_q;
    assign touch_o   = idle_req && !wr_i && hit_i;
    assign wr_en_o   = idle_req && wr_i && hit_i;
    // Write-through goes out regardless of hit
    assign mem_we_o  = idle_req && wr_i;
    assign start_o   = idle_req && !wr_i && !hit_i;
    assign refill_o  = (state_q == ST_REFILL);
    assign busy_o    = (state_q != ST_IDLE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q     <= ST_IDLE;
            rsp_valid_o <= 1'b0;
            rsp_hit_o   <= 1'b0;
        end else begin
            rsp_valid_o <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (req_i) begin
                        if (wr_i || hit_i) begin
                            rsp_valid_o <= 1'b1;
                            rsp_hit_o   <= hit_i;
                        end else begin
                            state_q <= ST_WAIT;
                        end
                    end
                end
                ST_WAIT: begin
                    if (done_i) begin
                        state_q <= ST_REFILL;
                    end
                end
                ST_REFILL: begin
                    state_q     <= ST_IDLE;
                    rsp_valid_o <= 1'b1;
                    rsp_hit_o   <= 1'b0;
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start_o) begin
            miss_addr_q <= addr_i;
        end
        if (idle_req) begin
            rsp_data_o <= rd_data_i;
        end else if (refill_o) begin
            rsp_data_o <= mem_data_i;
        end
    end

endmodule

// ==== logic/l3_mem_timer.sv ====
`include "l3_cfg.svh"

module l3_mem_timer import l3_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic start_i,
    output logic done_o
);

    localparam int CNT_W = $clog2(`L3_MEM_LAT + 1);

    logic [CNT_W-1:0] count_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count_q <= '0;
            done_o  <= 1'b0;
        end else begin
            // Registered done lands exactly latency cycles after start
            done_o <= (count_q == CNT_W'(1));
            if (start_i) begin
                count_q <= CNT_W'(`L3_MEM_LAT);
            end else if (count_q != '0) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

endmodule

// ==== logic/l3_backing_mem.sv ====
`include "l3_cfg.svh"

module l3_backing_mem (
    input  logic                  clk,
    input  logic                  we_i,
    input  logic [`L3_ADDR_W-1:0] addr_i,
    input  logic [3:0]            be_i,
    input  logic [31:0]           wdata_i,
    output logic [31:0]           rdata_o
);

    localparam int WORDS = 2 ** (`L3_ADDR_W - 2);

    logic [31:0]           mem_q [WORDS];
    logic [`L3_ADDR_W-3:0] word_addr;

    assign word_addr = addr_i[`L3_ADDR_W-1:2];

    // Known contents so refills can be predicted
    initial begin
        for (int i = 0; i < WORDS; i++) begin
            mem_q[i] = 32'(i) * 32'h0101_0101 + 32'h00C0_FFEE;
        end
    end

    always_ff @(posedge clk) begin
        if (we_i) begin
            for (int b = 0; b < 4; b++) begin
                if (be_i[b]) begin
                    mem_q[word_addr][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

    assign rdata_o = mem_q[word_addr];

endmodule

// ==== logic/l3_subsys.sv ====
`include "l3_cfg.svh"

module l3_subsys import l3_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_i,
    input  logic                  wr_i,
    input  logic [`L3_ADDR_W-1:0] addr_i,
    input  word_t                 wdata_i,
    input  logic [3:0]            be_i,
    output logic                  busy_o,
    output logic                  rsp_valid_o,
    output logic                  rsp_hit_o,
    output word_t                 rsp_data_o
);

    logic [`L3_ADDR_W-1:0] lk_addr;
    logic                  touch;
    logic                  wr_en;
    logic                  refill;
    logic                  mem_we;
    logic                  start;
    logic                  done;
    logic                  hit;
    word_t                 rd_data;
    word_t                 mem_rdata;

    l3_miss_fsm miss_fsm_i (
        .clk         (clk),
        .rst         (rst),
        .req_i       (req_i),
        .wr_i        (wr_i),
        .addr_i      (addr_i),
        .hit_i       (hit),
        .rd_data_i   (rd_data),
        .mem_data_i  (mem_rdata),
        .done_i      (done),
        .lk_addr_o   (lk_addr),
        .touch_o     (touch),
        .wr_en_o     (wr_en),
        .refill_o    (refill),
        .mem_we_o    (mem_we),
        .start_o     (start),
        .busy_o      (busy_o),
        .rsp_valid_o (rsp_valid_o),
        .rsp_hit_o   (rsp_hit_o),
        .rsp_data_o  (rsp_data_o)
    );

    l3_mem_timer mem_timer_i (
        .clk     (clk),
        .rst     (rst),
        .start_i (start),
        .done_o  (done)
    );

    l3_lookup lookup_i (
        .clk         (clk),
        .rst         (rst),
        .addr_i      (lk_addr),
        .touch_i     (touch),
        .wr_en_i     (wr_en),
        .refill_i    (refill),
        .wdata_i     (wdata_i),
        .be_i        (be_i),
        .fill_data_i (mem_rdata),
        .hit_o       (hit),
        .rd_data_o   (rd_data)
    );

    // Memory shares the lookup address
    l3_backing_mem backing_mem_i (
        .clk     (clk),
        .we_i    (mem_we),
        .addr_i  (lk_addr),
        .be_i    (be_i),
        .wdata_i (wdata_i),
        .rdata_o (mem_rdata)
    );

endmodule

// ==== test/l3_subsys_sva.sv ====
`include "l3_cfg.svh"

module l3_subsys_sva (
    input logic clk,
    input logic rst,
    input logic req_i,
    input logic wr_i,
    input logic hit_i,
    input logic busy_i,
    input logic rsp_valid_i
);

    timeunit 1ns;
    timeprecision 1ps;

    // Busy cycles between a read miss and its response
    localparam int MISS_CYC = `L3_MEM_LAT + 2;

    int fail_count = 0;

    reset_quiet: assert property (@(posedge clk) rst |-> (!busy_i && !rsp_valid_i))
        else begin
            fail_count++;
            $error("busy or response high while in reset");
        end

    hit_or_write_rsp: assert property (@(posedge clk) disable iff (rst)
        (req_i && !busy_i && (hit_i || wr_i)) |=> rsp_valid_i)
        else begin
            fail_count++;
            $error("hit or write request got no response on the next cycle");
        end

    read_miss_rsp: assert property (@(posedge clk) disable iff (rst)
        (req_i && !busy_i && !wr_i && !hit_i)
            |=> (busy_i && !rsp_valid_i) [*MISS_CYC] ##1 (rsp_valid_i && !busy_i))
        else begin
            fail_count++;
            $error("read miss response timing or busy level wrong");
        end

    no_req_when_busy: assert property (@(posedge clk) disable iff (rst) !(req_i && busy_i))
        else begin
            fail_count++;
            $error("request strobed while busy");
        end

    // A hit or write accepted right after a response brings its own pulse
    single_rsp_pulse: assert property (@(posedge clk) disable iff (rst)
        (rsp_valid_i && !(req_i && !busy_i && (hit_i || wr_i))) |=> !rsp_valid_i)
        else begin
            fail_count++;
            $error("response valid lasted two cycles");
        end

endmodule

bind l3_subsys l3_subsys_sva subsys_sva_i (
    .clk         (clk),
    .rst         (rst),
    .req_i       (req_i),
    .wr_i        (wr_i),
    .hit_i       (hit),
    .busy_i      (busy_o),
    .rsp_valid_i (rsp_valid_o)
);

// ==== test/l3_subsys_tb.sv ====
`include "l3_cfg.svh"

module l3_subsys_tb import l3_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int WORDS    = 2 ** (`L3_ADDR_W - 2);
    localparam int SET_BITS = $clog2(`L3_SETS);
    localparam int MISS_LAT = `L3_MEM_LAT + 2;
    localparam int TIMEOUT  = `L3_MEM_LAT + 10;

    logic                  clk;
    logic                  rst;
    logic                  req;
    logic                  wr;
    logic [`L3_ADDR_W-1:0] addr;
    word_t                 wdata;
    logic [3:0]            be;
    logic                  busy;
    logic                  rsp_valid;
    logic                  rsp_hit;
    word_t                 rsp_data;

    // Reference memory image and per-set recency lists with the most recent tag first
    word_t model_mem [WORDS];
    int    lru_tag [`L3_SETS][`L3_WAYS];
    int    lru_cnt [`L3_SETS];

    int    errors    = 0;
    logic  timed_out = 1'b0;

    l3_subsys l3_subsys_i (
        .clk         (clk),
        .rst         (rst),
        .req_i       (req),
        .wr_i        (wr),
        .addr_i      (addr),
        .wdata_i     (wdata),
        .be_i        (be),
        .busy_o      (busy),
        .rsp_valid_o (rsp_valid),
        .rsp_hit_o   (rsp_hit),
        .rsp_data_o  (rsp_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [`L3_ADDR_W-1:0] make_addr(input int tag, input int set_n);
        return (`L3_ADDR_W)'(tag * 4 * `L3_SETS + set_n * 4);
    endfunction

    function automatic int find_pos(input int set_n, input int tag);
        for (int i = 0; i < lru_cnt[set_n]; i++) begin
            if (lru_tag[set_n][i] == tag) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic void move_to_front(input int set_n, input int pos, input int tag);
        for (int i = pos; i > 0; i--) begin
            lru_tag[set_n][i] = lru_tag[set_n][i-1];
        end
        lru_tag[set_n][0] = tag;
    endfunction

    task automatic issue_request(input string name, input logic wr_v,
                                 input logic [`L3_ADDR_W-1:0] a, input word_t wd,
                                 input logic [3:0] be_v);
        int    set_n;
        int    tag;
        int    word;
        int    pos;
        int    waited;
        int    lat;
        int    exp_lat;
        logic  exp_hit;
        word_t exp_data;
        if (timed_out) begin
            return;
        end
        set_n    = int'(a[SET_BITS+1:2]);
        tag      = int'(a[`L3_ADDR_W-1:SET_BITS+2]);
        word     = int'(a[`L3_ADDR_W-1:2]);
        pos      = find_pos(set_n, tag);
        exp_hit  = (pos >= 0);
        exp_data = model_mem[word];
        exp_lat  = (wr_v || exp_hit) ? 0 : MISS_LAT;
        waited   = 0;
        while (busy && waited < TIMEOUT) begin
            @(posedge clk);
            #5;
            waited++;
        end
        if (busy) begin
            $display("Timed out in %s waiting for the cache to go idle", name);
            timed_out = 1'b1;
            return;
        end
        req   = 1'b1;
        wr    = wr_v;
        addr  = a;
        wdata = wd;
        be    = be_v;
        @(posedge clk);
        #5;
        req = 1'b0;
        lat = 0;
        while (!rsp_valid && lat < TIMEOUT) begin
            @(posedge clk);
            #5;
            lat++;
        end
        if (!rsp_valid) begin
            $display("Timed out in %s waiting for a response", name);
            timed_out = 1'b1;
            return;
        end
        assert (rsp_hit === exp_hit) else begin
            $display("ERROR %s: hit expected %0b actual %0b", name, exp_hit, rsp_hit);
            errors++;
        end
        assert (lat == exp_lat) else begin
            $display("ERROR %s: latency expected %0d actual %0d", name, exp_lat, lat);
            errors++;
        end
        if (!wr_v) begin
            assert (rsp_data === exp_data) else begin
                $display("ERROR %s: data expected %h actual %h", name, exp_data, rsp_data);
                errors++;
            end
        end
        // Model takes every write and allocates only on read misses
        if (wr_v) begin
            for (int i = 0; i < 4; i++) begin
                if (be_v[i]) begin
                    model_mem[word][8*i +: 8] = wd[8*i +: 8];
                end
            end
        end
        if (exp_hit) begin
            move_to_front(set_n, pos, tag);
        end else if (!wr_v) begin
            if (lru_cnt[set_n] < `L3_WAYS) begin
                lru_cnt[set_n]++;
            end
            move_to_front(set_n, lru_cnt[set_n] - 1, tag);
        end
    endtask

    initial begin
        logic [31:0] rng;
        logic [31:0] wrand;
        int          sva_fails;
        rng   = 32'h2a01;
        req   = 1'b0;
        wr    = 1'b0;
        addr  = '0;
        wdata = '0;
        be    = '0;
        rst   = 1'b0;
        for (int i = 0; i < WORDS; i++) begin
            model_mem[i] = 32'(i) * 32'h0101_0101 + 32'h00C0_FFEE;
        end
        for (int s = 0; s < `L3_SETS; s++) begin
            lru_cnt[s] = 0;
        end
        #1 rst = 1'b1;
        repeat (16) @(posedge clk);
        #5 rst = 1'b0;
        @(posedge clk);
        #5;

        issue_request("cold_miss", 1'b0, make_addr(1, 5), '0, 4'h0);
        issue_request("repeat_hit", 1'b0, make_addr(1, 5), '0, 4'h0);

        issue_request("write_hit", 1'b1, make_addr(1, 5), 32'hAABB_CCDD, 4'b0101);
        issue_request("merged_hit", 1'b0, make_addr(1, 5), '0, 4'h0);
        for (int t = 2; t < 6; t++) begin
            issue_request("evict_fill", 1'b0, make_addr(t, 5), '0, 4'h0);
        end
        issue_request("merged_after_evict", 1'b0, make_addr(1, 5), '0, 4'h0);

        issue_request("write_miss", 1'b1, make_addr(3, 7), 32'h5A00_0000, 4'b1000);
        issue_request("read_after_wmiss", 1'b0, make_addr(3, 7), '0, 4'h0);

        // Fill set 9, touch all but tag 0, then force an eviction
        for (int t = 0; t < 4; t++) begin
            issue_request("lru_fill", 1'b0, make_addr(t, 9), '0, 4'h0);
        end
        for (int t = 1; t < 4; t++) begin
            issue_request("lru_touch", 1'b0, make_addr(t, 9), '0, 4'h0);
        end
        issue_request("lru_new_tag", 1'b0, make_addr(4, 9), '0, 4'h0);
        for (int t = 1; t < 4; t++) begin
            issue_request("lru_kept", 1'b0, make_addr(t, 9), '0, 4'h0);
        end
        issue_request("lru_evicted", 1'b0, make_addr(0, 9), '0, 4'h0);

        for (int n = 0; n < 300; n++) begin
            rng   = xorshift32(rng);
            wrand = xorshift32(rng);
            issue_request("random_mix", (rng[9:8] == 2'b00),
                          make_addr(int'(rng[15:4] % 6), int'(rng[3:0] % 3)),
                          wrand, rng[19:16]);
        end

        repeat (4) @(posedge clk);
        sva_fails = l3_subsys_i.subsys_sva_i.fail_count;
        $display("Summary: %0d check errors, %0d assertion failures, timeout %0b",
                 errors, sva_fails, timed_out);
        if (errors == 0 && sva_fails == 0 && !timed_out) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+logic
logic/l3_pkg.sv
logic/l3_set_ram.sv
logic/l3_lookup.sv
logic/l3_miss_fsm.sv
logic/l3_mem_timer.sv
logic/l3_backing_mem.sv
logic/l3_subsys.sv
test/l3_subsys_sva.sv
test/l3_subsys_tb.sv

// ==== Bender.yml ====
package:
  name: l3_subsys

sources:
  - include_dirs:
      - logic
    files:
      - logic/l3_pkg.sv
      - logic/l3_set_ram.sv
      - logic/l3_lookup.sv
      - logic/l3_miss_fsm.sv
      - logic/l3_mem_timer.sv
      - logic/l3_backing_mem.sv
      - logic/l3_subsys.sv
  - target: test
    include_dirs:
      - logic
    files:
      - test/l3_subsys_sva.sv
      - test/l3_subsys_tb.sv
